// File: rtl/pdp_cfg_pkg.sv
`default_nettype none

package pdp_cfg_pkg;

   localparam int fifo_depth = 8;
   localparam int fifo_ptr_w = $clog2(fifo_depth);
   localparam int count_w = $clog2(fifo_depth + 1); // holds 0 to fifo_depth.
   localparam int kw_w = 3;

   localparam int axil_addr_w = 4;
   localparam int axil_data_w = 32;

   localparam logic [axil_addr_w-1:0] addr_cfg = 4'h0;
   localparam logic [axil_addr_w-1:0] addr_sample = 4'h4;
   localparam logic [axil_addr_w-1:0] addr_result = 4'h8;
   localparam logic [axil_addr_w-1:0] addr_status = 4'hc;

   localparam logic [1:0] resp_okay = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   typedef enum logic [1:0] {
      fmt_int8  = 2'd0,
      fmt_int16 = 2'd1,
      fmt_fp16  = 2'd2
   } pdp_fmt_e;

   // kernel_width n gives a window of n + 1 samples.
   typedef struct packed {
      pdp_fmt_e          fmt;
      logic [kw_w-1:0]   kernel_width;
   } pdp_cfg_t;

   localparam pdp_cfg_t cfg_reset = '{fmt: fmt_int16, kernel_width: '0};

   typedef struct packed {
      logic [axil_addr_w-1:0] awaddr;
      logic                   awvalid;
      logic [axil_data_w-1:0] wdata;
      logic [3:0]             wstrb;
      logic                   wvalid;
      logic                   bready;
      logic [axil_addr_w-1:0] araddr;
      logic                   arvalid;
      logic                   rready;
   } axil_req_t;

   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic [1:0]             bresp;
      logic                   bvalid;
      logic                   arready;
      logic [axil_data_w-1:0] rdata;
      logic [1:0]             rresp;
      logic                   rvalid;
   } axil_rsp_t;

endpackage

`default_nettype wire

// File: rtl/pdp_data_pkg.sv
`default_nettype none

package pdp_data_pkg;

   localparam int sample_w = 22;
   localparam int data_w = 16; // bits that carry a value in every format.

   typedef logic [sample_w-1:0] pdp_sample_t;

   // the format travels with the value so a read reports how it was pooled.
   typedef struct packed {
      pdp_cfg_pkg::pdp_fmt_e fmt;
      pdp_sample_t           value;
   } pdp_result_t;

endpackage

`default_nettype wire

// File: rtl/pdp_min_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_min_cmp (
   input  wire pdp_cfg_pkg::pdp_fmt_e       fmt,
   input  wire pdp_data_pkg::pdp_sample_t   a,
   input  wire pdp_data_pkg::pdp_sample_t   b,
   output pdp_data_pkg::pdp_sample_t        min_out
);
   import pdp_cfg_pkg::*;
   import pdp_data_pkg::*;

   logic [data_w-1:0] a16;
   logic [data_w-1:0] b16;
   logic [data_w-1:0] fp_min;
   logic [data_w-1:0] int_min;
   logic [data_w-1:0] lane_min;
   logic [data_w-1:0] sel;
   logic              a_zero;
   logic              b_zero;

   assign a16 = a[data_w-1:0];
   assign b16 = b[data_w-1:0];
   assign a_zero = (a16 == '0);
   assign b_zero = (b16 == '0);

   // sign and magnitude are compared apart, no subtraction needed.
   always_comb begin
      if (!a16[15] && !b16[15]) begin
         fp_min = (a16[14:0] < b16[14:0]) ? a16 : b16;
      end else if (a16[15] && b16[15]) begin
         fp_min = (a16[14:0] > b16[14:0]) ? a16 : b16; // larger negative is smaller.
      end else if (a16[15]) begin
         fp_min = a16;
      end else begin
         fp_min = b16;
      end
   end

   // a zero counts as an empty slot and gives way to any real value.
   always_comb begin
      if (a_zero && !b_zero) begin
         int_min = b16;
      end else if (b_zero && !a_zero) begin
         int_min = a16;
      end else begin
         int_min = ($signed(a16) < $signed(b16)) ? a16 : b16;
      end
   end

   assign lane_min[15:8] = (a16[15:8] < b16[15:8]) ? a16[15:8] : b16[15:8];
   assign lane_min[7:0] = (a16[7:0] < b16[7:0]) ? a16[7:0] : b16[7:0];

   always_comb begin
      case (fmt)
         fmt_fp16: sel = fp_min;
         fmt_int8: sel = lane_min;
         default: sel = int_min;
      endcase
      min_out = {{(sample_w - data_w){1'b0}}, sel};
   end

endmodule

`default_nettype wire

// File: rtl/pdp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_fifo #(
   parameter type payload_t = logic
) (
   input  wire logic                              nvdla_core_clk,
   input  wire logic                              rst,
   input  wire payload_t                          in_data,
   input  wire logic                              in_valid,
   output logic                                   in_ready,
   output payload_t                               out_data,
   output logic                                   out_valid,
   input  wire logic                              out_ready,
   output logic [pdp_cfg_pkg::count_w-1:0]        count
);
   import pdp_cfg_pkg::*;

   payload_t              mem [fifo_depth];
   logic [fifo_ptr_w-1:0] wr_ptr;
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic                  push;
   logic                  pop;

   assign in_ready = (count != count_w'(fifo_depth));
   assign out_valid = (count != '0);
   assign push = in_valid && in_ready;
   assign pop = out_valid && out_ready;
   assign out_data = mem[rd_ptr];

   // pointers wrap on their own since the depth is a power of two.
   always_ff @(posedge nvdla_core_clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge nvdla_core_clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

endmodule

`default_nettype wire

// File: rtl/pdp_pool1d.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_pool1d (
   input  wire logic                        nvdla_core_clk,
   input  wire logic                        rst,
   input  wire pdp_cfg_pkg::pdp_cfg_t       cfg,
   input  wire pdp_data_pkg::pdp_sample_t   smp_data,
   input  wire logic                        smp_valid,
   output logic                             smp_ready,
   output pdp_data_pkg::pdp_result_t        res_data,
   output logic                             res_valid,
   input  wire logic                        res_ready,
   output logic                             busy
);
   import pdp_cfg_pkg::*;
   import pdp_data_pkg::*;

   pdp_cfg_t        win_cfg;
   pdp_sample_t     acc;
   pdp_sample_t     min_val;
   logic [kw_w-1:0] cnt;
   logic [kw_w-1:0] cnt_next;
   logic [kw_w-1:0] kw_eff;
   logic            active;
   logic            hold;
   logic            take;
   logic            last;

   pdp_min_cmp u_min_cmp (
      .fmt     (win_cfg.fmt),
      .a       (acc),
      .b       (smp_data),
      .min_out (min_val)
   );

   assign smp_ready = !hold; // no intake while a result waits.
   assign take = smp_valid && smp_ready;

   // the first sample of a window still sees the live configuration.
   assign kw_eff = active ? win_cfg.kernel_width : cfg.kernel_width;
   assign cnt_next = active ? cnt + 1'b1 : '0;
   assign last = (cnt_next == kw_eff);

   always_ff @(posedge nvdla_core_clk) begin
      if (rst) begin
         active <= 1'b0;
         hold <= 1'b0;
         cnt <= '0;
      end else if (take) begin
         cnt <= cnt_next;
         active <= !last;
         hold <= last;
      end else if (hold && res_ready) begin
         hold <= 1'b0;
      end
   end

   always_ff @(posedge nvdla_core_clk) begin
      if (take) begin
         if (!active) begin
            win_cfg <= cfg;
            acc <= {{(sample_w - data_w){1'b0}}, smp_data[data_w-1:0]};
         end else begin
            acc <= min_val;
         end
      end
   end

   always_comb begin
      res_data.fmt = win_cfg.fmt;
      res_data.value = acc;
   end

   assign res_valid = hold;
   assign busy = active || hold;

endmodule

`default_nettype wire

// File: rtl/pdp_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_reg_if (
   input  wire logic                              nvdla_core_clk,
   input  wire logic                              rst,
   input  wire pdp_cfg_pkg::axil_req_t            axil_req,
   output pdp_cfg_pkg::axil_rsp_t                 axil_rsp,
   output pdp_cfg_pkg::pdp_cfg_t                  cfg,
   output pdp_data_pkg::pdp_sample_t              smp_data,
   output logic                                   smp_valid,
   input  wire logic                              smp_ready,
   input  wire pdp_data_pkg::pdp_result_t         res_data,
   input  wire logic                              res_valid,
   output logic                                   res_ready,
   input  wire logic [pdp_cfg_pkg::count_w-1:0]   in_count,
   input  wire logic [pdp_cfg_pkg::count_w-1:0]   res_count,
   input  wire logic                              busy
);
   import pdp_cfg_pkg::*;
   import pdp_data_pkg::*;

   logic                   wr_both;
   logic                   wr_is_sample;
   logic                   wr_ok;
   logic                   ar_ok;
   logic                   bvalid_q;
   logic                   rvalid_q;
   logic [axil_data_w-1:0] rdata_q;
   logic [1:0]             rresp_q;
   logic [axil_data_w-1:0] status_word;

   // address and data are taken together, and never while a response waits.
   assign wr_both = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
   assign wr_is_sample = (axil_req.awaddr == addr_sample);
   assign wr_ok = wr_both && (!wr_is_sample || smp_ready); // a full input FIFO stalls.

   assign smp_valid = wr_both && wr_is_sample;
   assign smp_data = pdp_sample_t'(axil_req.wdata[sample_w-1:0]);

   assign ar_ok = axil_req.arvalid && !rvalid_q;
   assign res_ready = ar_ok && (axil_req.araddr == addr_result);

   assign status_word = {15'b0, busy,
                         {(8 - count_w){1'b0}}, in_count,
                         {(8 - count_w){1'b0}}, res_count};

   always_ff @(posedge nvdla_core_clk) begin
      if (rst) begin
         cfg <= cfg_reset;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_ok && axil_req.awaddr == addr_cfg && axil_req.wstrb[0]) begin
            cfg <= pdp_cfg_t'(axil_req.wdata[$bits(pdp_cfg_t)-1:0]);
         end
         if (wr_ok) begin
            bvalid_q <= 1'b1;
         end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
         end
         if (ar_ok) begin
            rvalid_q <= 1'b1;
         end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge nvdla_core_clk) begin
      if (ar_ok) begin
         rresp_q <= resp_okay;
         case (axil_req.araddr)
            addr_cfg: rdata_q <= {{(axil_data_w - $bits(pdp_cfg_t)){1'b0}}, cfg};
            addr_result: begin
               if (res_valid) begin
                  rdata_q <= {6'b0, res_data.fmt, 2'b0, res_data.value};
               end else begin
                  rdata_q <= '0; // nothing pooled yet.
                  rresp_q <= resp_slverr;
               end
            end
            addr_status: rdata_q <= status_word;
            default: rdata_q <= '0;
         endcase
      end
   end

   always_comb begin
      axil_rsp.awready = wr_ok;
      axil_rsp.wready = wr_ok;
      axil_rsp.bresp = resp_okay;
      axil_rsp.bvalid = bvalid_q;
      axil_rsp.arready = !rvalid_q;
      axil_rsp.rdata = rdata_q;
      axil_rsp.rresp = rresp_q;
      axil_rsp.rvalid = rvalid_q;
   end

endmodule

`default_nettype wire

// File: rtl/pdp_top.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_top (
   input  wire logic                     nvdla_core_clk,
   input  wire logic                     rst,
   input  wire pdp_cfg_pkg::axil_req_t   axil_req,
   output pdp_cfg_pkg::axil_rsp_t        axil_rsp
);
   import pdp_cfg_pkg::*;
   import pdp_data_pkg::*;

   pdp_cfg_t           cfg;
   pdp_sample_t        wr_smp;
   logic               wr_smp_valid;
   logic               wr_smp_ready;
   pdp_sample_t        eng_smp;
   logic               eng_smp_valid;
   logic               eng_smp_ready;
   pdp_result_t        eng_res;
   logic               eng_res_valid;
   logic               eng_res_ready;
   pdp_result_t        rd_res;
   logic               rd_res_valid;
   logic               rd_res_ready;
   logic [count_w-1:0] in_count;
   logic [count_w-1:0] res_count;
   logic               busy;

   pdp_reg_if u_reg_if (
      .nvdla_core_clk (nvdla_core_clk),
      .rst            (rst),
      .axil_req       (axil_req),
      .axil_rsp       (axil_rsp),
      .cfg            (cfg),
      .smp_data       (wr_smp),
      .smp_valid      (wr_smp_valid),
      .smp_ready      (wr_smp_ready),
      .res_data       (rd_res),
      .res_valid      (rd_res_valid),
      .res_ready      (rd_res_ready),
      .in_count       (in_count),
      .res_count      (res_count),
      .busy           (busy)
   );

   pdp_fifo #(.payload_t(pdp_sample_t)) u_in_fifo (
      .nvdla_core_clk (nvdla_core_clk),
      .rst            (rst),
      .in_data        (wr_smp),
      .in_valid       (wr_smp_valid),
      .in_ready       (wr_smp_ready),
      .out_data       (eng_smp),
      .out_valid      (eng_smp_valid),
      .out_ready      (eng_smp_ready),
      .count          (in_count)
   );

   pdp_pool1d u_pool1d (
      .nvdla_core_clk (nvdla_core_clk),
      .rst            (rst),
      .cfg            (cfg),
      .smp_data       (eng_smp),
      .smp_valid      (eng_smp_valid),
      .smp_ready      (eng_smp_ready),
      .res_data       (eng_res),
      .res_valid      (eng_res_valid),
      .res_ready      (eng_res_ready),
      .busy           (busy)
   );

   pdp_fifo #(.payload_t(pdp_result_t)) u_res_fifo (
      .nvdla_core_clk (nvdla_core_clk),
      .rst            (rst),
      .in_data        (eng_res),
      .in_valid       (eng_res_valid),
      .in_ready       (eng_res_ready),
      .out_data       (rd_res),
      .out_valid      (rd_res_valid),
      .out_ready      (rd_res_ready),
      .count          (res_count)
   );

endmodule

`default_nettype wire

// File: tb/pdp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_checker (
   input wire logic                              nvdla_core_clk,
   input wire logic                              rst,
   input wire logic                              bvalid,
   input wire logic                              bready,
   input wire logic                              rvalid,
   input wire logic                              rready,
   input wire logic                              push_valid,
   input wire logic                              push_ready,
   input wire logic [pdp_cfg_pkg::count_w-1:0]   push_level,
   input wire logic                              pop_valid,
   input wire logic                              pop_ready,
   input wire logic [pdp_cfg_pkg::count_w-1:0]   pop_level
);
   import pdp_cfg_pkg::*;

   int fail_count = 0;

   b_hold: assert property (@(posedge nvdla_core_clk) disable iff (rst)
      bvalid && !bready |=> bvalid) else begin
      fail_count++;
      $error("bvalid dropped before bready");
   end

   r_hold: assert property (@(posedge nvdla_core_clk) disable iff (rst)
      rvalid && !rready |=> rvalid) else begin
      fail_count++;
      $error("rvalid dropped before rready");
   end

   // a push into a full FIFO would carry the level past its depth.
   no_push_full: assert property (@(posedge nvdla_core_clk) disable iff (rst)
      push_valid && push_ready |=>
         push_level != '0 && push_level <= count_w'(fifo_depth)) else begin
      fail_count++;
      $error("push accepted into a full FIFO");
   end

   // a pop from an empty FIFO would wrap the level around to its top.
   no_pop_empty: assert property (@(posedge nvdla_core_clk) disable iff (rst)
      pop_valid && pop_ready |=> pop_level < count_w'(fifo_depth)) else begin
      fail_count++;
      $error("pop accepted from an empty FIFO");
   end

endmodule

// the FIFO has no response channels, so those inputs are tied idle.
bind pdp_fifo pdp_checker u_checker (
   .nvdla_core_clk (nvdla_core_clk),
   .rst            (rst),
   .bvalid         (1'b0),
   .bready         (1'b1),
   .rvalid         (1'b0),
   .rready         (1'b1),
   .push_valid     (in_valid),
   .push_ready     (in_ready),
   .push_level     (count),
   .pop_valid      (out_valid),
   .pop_ready      (out_ready),
   .pop_level      (count)
);

bind pdp_reg_if pdp_checker u_checker (
   .nvdla_core_clk (nvdla_core_clk),
   .rst            (rst),
   .bvalid         (axil_rsp.bvalid),
   .bready         (axil_req.bready),
   .rvalid         (axil_rsp.rvalid),
   .rready         (axil_req.rready),
   .push_valid     (smp_valid),
   .push_ready     (smp_ready),
   .push_level     (in_count),
   .pop_valid      (res_valid),
   .pop_ready      (res_ready),
   .pop_level      (res_count)
);

`default_nettype wire

// File: tb/pdp_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pdp_top_tb;
   import pdp_cfg_pkg::*;
   import pdp_data_pkg::*;

   localparam int poll_max = 16;
   localparam int windows = 4;
   localparam int stall_len = 24; // more than both FIFOs and the engine can hold.
   // worst case bus transactions of all tests, each status poll loop counted at its limit.
   localparam int bus_ops = 5
                          + 3 * (1 + poll_max + windows) + windows * (1 + 4 + 8)
                          + (1 + 16 + poll_max + 4)
                          + (1 + 12 + poll_max + 4)
                          + (2 + stall_len + stall_len * (poll_max + 1))
                          + 2;
   localparam int timeout_cycles = 20 * bus_ops;

   logic      nvdla_core_clk;
   logic      rst;
   axil_req_t req;
   axil_rsp_t rsp;

   int    errors;
   int    checks;
   int    test_errors;
   int    cycles;
   int    assert_fails;
   string test_name;

   pdp_top uut (
      .nvdla_core_clk (nvdla_core_clk),
      .rst            (rst),
      .axil_req       (req),
      .axil_rsp       (rsp)
   );

   always #4 nvdla_core_clk = ~nvdla_core_clk;

   always @(posedge nvdla_core_clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout after %0d cycles, a bus handshake never completed", cycles);
         $display("sim failed");
         $finish;
      end
   end

   task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                             input logic [axil_data_w-1:0] data, output logic [1:0] resp);
      @(posedge nvdla_core_clk);
      req.awaddr <= addr;
      req.awvalid <= 1'b1;
      req.wdata <= data;
      req.wstrb <= 4'hf;
      req.wvalid <= 1'b1;
      do begin
         @(negedge nvdla_core_clk);
      end while (!(rsp.awready && rsp.wready)); // address and data go in together.
      @(posedge nvdla_core_clk);
      req.awvalid <= 1'b0;
      req.wvalid <= 1'b0;
      req.bready <= 1'b1;
      do begin
         @(negedge nvdla_core_clk);
      end while (!rsp.bvalid);
      resp = rsp.bresp;
      @(posedge nvdla_core_clk);
      req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [axil_addr_w-1:0] addr,
                            output logic [axil_data_w-1:0] data, output logic [1:0] resp);
      @(posedge nvdla_core_clk);
      req.araddr <= addr;
      req.arvalid <= 1'b1;
      do begin
         @(negedge nvdla_core_clk);
      end while (!rsp.arready);
      @(posedge nvdla_core_clk);
      req.arvalid <= 1'b0;
      req.rready <= 1'b1;
      do begin
         @(negedge nvdla_core_clk);
      end while (!rsp.rvalid);
      data = rsp.rdata;
      resp = rsp.rresp;
      @(posedge nvdla_core_clk);
      req.rready <= 1'b0;
   endtask

   task automatic check_result(input pdp_result_t exp, input pdp_result_t act);
      checks++;
      if (act !== exp) begin
         $display("ERROR %s: expected fmt %0d value %h, got fmt %0d value %h",
                  test_name, exp.fmt, exp.value, act.fmt, act.value);
         test_errors++;
      end
   endtask

   task automatic check_cfg(input pdp_cfg_t exp, input pdp_cfg_t act);
      checks++;
      if (act !== exp) begin
         $display("ERROR %s: expected cfg %h, got %h", test_name, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_resp(input logic [1:0] exp, input logic [1:0] act);
      checks++;
      if (act !== exp) begin
         $display("ERROR %s: expected resp %b, got %b", test_name, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_count(input logic [count_w-1:0] exp, input logic [count_w-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("ERROR %s: expected count %0d, got %0d", test_name, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_busy(input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("ERROR %s: expected busy %b, got %b", test_name, exp, act);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("test %s: %s", test_name, (test_errors == 0) ? "ok" : "FAILED");
      errors += test_errors;
   endtask

   // fp16 order as an integer key, so that -0 still sorts below +0.
   function automatic logic [15:0] ref_pair_min(input pdp_fmt_e fmt, input logic [15:0] a,
                                                input logic [15:0] b);
      int         ka;
      int         kb;
      logic [7:0] hi;
      logic [7:0] lo;
      case (fmt)
         fmt_fp16: begin
            ka = a[15] ? -int'(a[14:0]) - 1 : int'(a[14:0]);
            kb = b[15] ? -int'(b[14:0]) - 1 : int'(b[14:0]);
            return (kb < ka) ? b : a;
         end
         fmt_int8: begin
            hi = (b[15:8] < a[15:8]) ? b[15:8] : a[15:8];
            lo = (b[7:0] < a[7:0]) ? b[7:0] : a[7:0];
            return {hi, lo};
         end
         default: begin
            if (a == 16'h0) return b; // zero is an empty slot.
            if (b == 16'h0) return a;
            return ($signed(b) < $signed(a)) ? b : a;
         end
      endcase
   endfunction

   task automatic pool_model(input pdp_fmt_e fmt, input logic [15:0] win[$],
                             output pdp_result_t exp);
      logic [15:0] acc;
      acc = win[0];
      for (int i = 1; i < win.size(); i++) begin
         acc = ref_pair_min(fmt, acc, win[i]);
      end
      exp.fmt = fmt;
      exp.value = {6'b0, acc};
   endtask

   function automatic pdp_result_t decode_result(input logic [axil_data_w-1:0] word);
      pdp_result_t r;
      r.fmt = pdp_fmt_e'(word[25:24]);
      r.value = word[21:0];
      return r;
   endfunction

   function automatic logic [axil_data_w-1:0] random_int16_word();
      logic [axil_data_w-1:0] r;
      r = $urandom();
      case (r[31:30])
         2'd0: r[15:0] = 16'h0;
         2'd1: r[15] = 1'b1;
         default: ;
      endcase
      return r;
   endfunction

   task automatic set_cfg(input pdp_fmt_e fmt, input logic [kw_w-1:0] kw);
      pdp_cfg_t   c;
      logic [1:0] resp;
      c.fmt = fmt;
      c.kernel_width = kw;
      axil_write(addr_cfg, {27'b0, c}, resp);
      check_resp(resp_okay, resp);
   endtask

   task automatic push_sample(input logic [axil_data_w-1:0] word);
      logic [1:0] resp;
      axil_write(addr_sample, word, resp);
      check_resp(resp_okay, resp);
   endtask

   task automatic read_result(output pdp_result_t r, output logic [1:0] resp);
      logic [axil_data_w-1:0] data;
      axil_read(addr_result, data, resp);
      r = decode_result(data);
   endtask

   task automatic wait_results(input int n);
      logic [axil_data_w-1:0] data;
      logic [1:0]             resp;
      int                     polls;
      polls = 0;
      do begin
         axil_read(addr_status, data, resp);
         polls++;
      end while (int'(data[7:0]) < n && polls < poll_max);
      if (int'(data[7:0]) < n) begin
         $display("%s: only %0d of %0d results appeared", test_name, data[7:0], n);
         test_errors++;
      end
   endtask

   task automatic pool_and_check(input pdp_fmt_e fmt, input logic [kw_w-1:0] kw,
                                 input logic [axil_data_w-1:0] words[$]);
      logic [15:0] win[$];
      pdp_result_t exp[$];
      pdp_result_t expected;
      pdp_result_t got;
      logic [1:0]  resp;
      set_cfg(fmt, kw);
      foreach (words[i]) begin
         push_sample(words[i]);
         win.push_back(words[i][15:0]);
         if (win.size() == int'(kw) + 1) begin
            pool_model(fmt, win, expected);
            exp.push_back(expected);
            win.delete();
         end
      end
      wait_results(exp.size());
      foreach (exp[i]) begin
         read_result(got, resp);
         check_resp(resp_okay, resp);
         check_result(exp[i], got);
      end
   endtask

   task automatic test_cfg();
      logic [axil_data_w-1:0] data;
      logic [1:0]             resp;
      start_test("cfg_readback");
      axil_read(addr_cfg, data, resp);
      check_resp(resp_okay, resp);
      check_cfg('{fmt: fmt_int16, kernel_width: 3'd0}, pdp_cfg_t'(data[4:0]));
      set_cfg(fmt_fp16, 3'd5);
      axil_read(addr_cfg, data, resp);
      check_cfg('{fmt: fmt_fp16, kernel_width: 3'd5}, pdp_cfg_t'(data[4:0]));
      set_cfg(fmt_int8, 3'd2);
      axil_read(addr_cfg, data, resp);
      check_cfg('{fmt: fmt_int8, kernel_width: 3'd2}, pdp_cfg_t'(data[4:0]));
      end_test();
   endtask

   task automatic test_int16();
      logic [axil_data_w-1:0] words[$];
      logic [axil_data_w-1:0] r;
      logic [kw_w-1:0]        widths[3];
      widths = '{3'd0, 3'd3, 3'd7};
      start_test("int16_min");
      foreach (widths[w]) begin
         words.delete();
         for (int i = 0; i < windows * (int'(widths[w]) + 1); i++) begin
            r = random_int16_word();
            if (i == 0) r[15:0] = 16'h0; // first window opens on an empty slot.
            words.push_back(r);
         end
         pool_and_check(fmt_int16, widths[w], words);
      end
      end_test();
   endtask

   task automatic test_fp16();
      logic [axil_data_w-1:0] words[$];
      logic [15:0]            fp_vals[12];
      // three directed windows of four, then a random one.
      fp_vals = '{16'h3c00, 16'hbc00, 16'hc000, 16'h4000,
                  16'h0001, 16'h7bff, 16'h0400, 16'h3000,
                  16'h8000, 16'h0000, 16'h8001, 16'h7c00};
      start_test("fp16_min");
      foreach (fp_vals[i]) words.push_back({16'h0, fp_vals[i]});
      repeat (4) words.push_back($urandom());
      pool_and_check(fmt_fp16, 3'd3, words);
      end_test();
   endtask

   task automatic test_int8();
      logic [axil_data_w-1:0] words[$];
      start_test("int8_lanes");
      repeat (windows * 3) words.push_back($urandom()); // upper bits are junk on purpose.
      pool_and_check(fmt_int8, 3'd2, words);
      end_test();
   endtask

   task automatic test_stall();
      logic [axil_data_w-1:0] words[$];
      logic [15:0]            one[$];
      pdp_result_t            exp[$];
      pdp_result_t            expected;
      pdp_result_t            got;
      logic [axil_data_w-1:0] data;
      logic [1:0]             resp;
      int                     stalled;
      start_test("stall_no_loss");
      set_cfg(fmt_int16, 3'd0);
      for (int i = 0; i < stall_len; i++) begin
         words.push_back($urandom());
         one.delete();
         one.push_back(words[i][15:0]);
         pool_model(fmt_int16, one, expected);
         exp.push_back(expected);
      end
      fork
         begin
            foreach (words[i]) push_sample(words[i]);
         end
         begin
            stalled = 0;
            while (stalled < 10) begin
               @(negedge nvdla_core_clk);
               if (req.awvalid && !rsp.awready) stalled++;
               else stalled = 0;
            end
            axil_read(addr_status, data, resp);
            check_count(count_w'(fifo_depth), data[0 +: count_w]);
            check_count(count_w'(fifo_depth), data[8 +: count_w]);
            check_busy(1'b1, data[16]); // the engine holds a result it cannot store.
            foreach (exp[i]) begin
               wait_results(1);
               read_result(got, resp);
               check_resp(resp_okay, resp);
               check_result(exp[i], got);
            end
         end
      join
      end_test();
   endtask

   task automatic test_empty();
      logic [axil_data_w-1:0] data;
      logic [1:0]             resp;
      pdp_result_t            got;
      start_test("empty_read");
      read_result(got, resp);
      check_resp(resp_slverr, resp);
      check_result('0, got);
      axil_read(addr_status, data, resp);
      check_resp(resp_okay, resp);
      check_count('0, data[0 +: count_w]);
      check_count('0, data[8 +: count_w]);
      check_busy(1'b0, data[16]);
      end_test();
   endtask

   initial begin
      nvdla_core_clk = 1'b0;
      rst = 1'b1;
      req = '0;
      errors = 0;
      checks = 0;
      cycles = 0;
      void'($urandom(32'hb445_a976));
      repeat (3) @(posedge nvdla_core_clk);
      rst <= 1'b0;
      test_cfg();
      test_int16();
      test_fp16();
      test_int8();
      test_stall();
      test_empty();
      assert_fails = uut.u_reg_if.u_checker.fail_count
                   + uut.u_in_fifo.u_checker.fail_count
                   + uut.u_res_fifo.u_checker.fail_count;
      $display("%0d checks, %0d errors, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
rtl/pdp_cfg_pkg.sv
rtl/pdp_data_pkg.sv
rtl/pdp_min_cmp.sv
rtl/pdp_fifo.sv
rtl/pdp_pool1d.sv
rtl/pdp_reg_if.sv
rtl/pdp_top.sv
tb/pdp_checker.sv
tb/pdp_top_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pdp_top_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+100
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
